/* build.f */
+incdir+hw
hw/mem_pipe_pkg.sv
hw/req_decode.sv
hw/avmm_reg_pipe.sv
hw/mem_exec.sv
hw/rsp_collect.sv
hw/mem_pipe_top.sv
sim/mem_pipe_tb.sv

/* hw/avmm_reg_pipe.sv */
// **************************************************
// Register stages between Avalon master and sink
// Waitrequest runs on its own delay line, almost full
// **************************************************
`default_nettype none

`include "mem_pipe_settings.svh"

module avmm_reg_pipe
(
    input  wire                            mem_sink,
    input  wire                            rst_n,
    input  wire                            src_read,
    input  wire                            src_write,
    input  wire mem_pipe_pkg::mem_addr_t   src_address,
    input  wire mem_pipe_pkg::mem_data_t   src_writedata,
    input  wire mem_pipe_pkg::mem_byteen_t src_byteenable,
    input  wire                            snk_waitrequest,
    input  wire mem_pipe_pkg::mem_data_t   snk_readdata,
    input  wire                            snk_readdatavalid,
    output logic                           src_waitrequest,
    output mem_pipe_pkg::mem_data_t        src_readdata,
    output logic                           src_readdatavalid,
    output logic                           snk_read,
    output logic                           snk_write,
    output mem_pipe_pkg::mem_addr_t        snk_address,
    output mem_pipe_pkg::mem_data_t        snk_writedata,
    output mem_pipe_pkg::mem_byteen_t      snk_byteenable
);
    import mem_pipe_pkg::*;

    localparam int NR = `MEM_REG_STAGES;
    localparam int NW = `MEM_WR_STAGES;

    // Source read/write only count when the delayed waitrequest is low
    logic src_rd_go;
    logic src_wr_go;

    assign src_rd_go = src_read && !src_waitrequest;
    assign src_wr_go = src_write && !src_waitrequest;

    generate
        if (NR == 0)
        begin : g_wires
            assign snk_read          = src_rd_go;
            assign snk_write         = src_wr_go;
            assign snk_address       = src_address;
            assign snk_writedata     = src_writedata;
            assign snk_byteenable    = src_byteenable;
            assign src_readdata      = snk_readdata;
            assign src_readdatavalid = snk_readdatavalid;
        end
        else
        begin : g_regs
            // Requests enter at 1 and leave at NR
            logic        rd_q    [1:NR];
            logic        wr_q    [1:NR];
            mem_addr_t   addr_q  [1:NR];
            mem_data_t   wdata_q [1:NR];
            mem_byteen_t be_q    [1:NR];
            // Responses enter at NR and leave at 1
            logic        rdv_q   [1:NR];
            mem_data_t   rdata_q [1:NR];

            always_ff @(posedge mem_sink or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    for (int i = 1; i <= NR; i++)
                    begin
                        rd_q[i]  <= 1'b0;
                        wr_q[i]  <= 1'b0;
                        rdv_q[i] <= 1'b0;
                    end
                end
                else
                begin
                    rd_q[1]    <= src_rd_go;
                    wr_q[1]    <= src_wr_go;
                    rdv_q[NR]  <= snk_readdatavalid;
                    for (int i = 2; i <= NR; i++)
                    begin
                        rd_q[i]    <= rd_q[i-1];
                        wr_q[i]    <= wr_q[i-1];
                        rdv_q[i-1] <= rdv_q[i];
                    end
                end
            end

            // Payload shifts without reset, qualified by the control bits
            always_ff @(posedge mem_sink)
            begin
                addr_q[1]   <= src_address;
                wdata_q[1]  <= src_writedata;
                be_q[1]     <= src_byteenable;
                rdata_q[NR] <= snk_readdata;
                for (int i = 2; i <= NR; i++)
                begin
                    addr_q[i]    <= addr_q[i-1];
                    wdata_q[i]   <= wdata_q[i-1];
                    be_q[i]      <= be_q[i-1];
                    rdata_q[i-1] <= rdata_q[i];
                end
            end

            assign snk_read          = rd_q[NR];
            assign snk_write         = wr_q[NR];
            assign snk_address       = addr_q[NR];
            assign snk_writedata     = wdata_q[NR];
            assign snk_byteenable    = be_q[NR];
            assign src_readdata      = rdata_q[1];
            assign src_readdatavalid = rdv_q[1];
        end
    endgenerate

    generate
        if (NW == 0)
        begin : g_wr_wire
            assign src_waitrequest = snk_waitrequest;
        end
        else
        begin : g_wr_shift
            // Sink waitrequest shifts in at bit 0
            logic [NW-1:0] wr_sr;

            always_ff @(posedge mem_sink or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    wr_sr <= '0;
                end
                else
                begin
                    wr_sr <= (wr_sr << 1) | NW'(snk_waitrequest);
                end
            end

            assign src_waitrequest = wr_sr[NW-1];
        end
    endgenerate

    // No stale response may leak out of reset, whatever the sink does
    a_no_rdv_in_reset: assert property (@(posedge mem_sink)
        !rst_n |-> !src_readdatavalid);

endmodule

`default_nettype wire

/* hw/mem_exec.sv */
// **************************************************
// Execute stage, request queue and byte-enabled memory
// Waitrequest raised early so in-flight requests fit
// **************************************************
`default_nettype none

`include "mem_pipe_settings.svh"

module mem_exec
(
    input  wire                            mem_sink,
    input  wire                            rst_n,
    input  wire                            sink_stall,
    input  wire                            snk_read,
    input  wire                            snk_write,
    input  wire mem_pipe_pkg::mem_addr_t   snk_address,
    input  wire mem_pipe_pkg::mem_data_t   snk_writedata,
    input  wire mem_pipe_pkg::mem_byteen_t snk_byteenable,
    output logic                           snk_waitrequest,
    output mem_pipe_pkg::mem_data_t        snk_readdata,
    output logic                           snk_readdatavalid
);
    import mem_pipe_pkg::*;

    localparam int DEPTH = `MEM_QUEUE_DEPTH;
    localparam int Q_AW  = $clog2(DEPTH);
    localparam int LAT   = `MEM_READ_LAT;
    localparam int NB    = `MEM_DATA_W / 8;
    // Requests that may still land after waitrequest goes up
    localparam int SLACK = `MEM_REG_STAGES + `MEM_WR_STAGES + 1;

    // Request queue storage
    logic        q_write [DEPTH];
    mem_addr_t   q_addr  [DEPTH];
    mem_data_t   q_wdata [DEPTH];
    mem_byteen_t q_be    [DEPTH];

    logic [Q_AW-1:0] wr_ptr;
    logic [Q_AW-1:0] rd_ptr;
    logic [Q_AW:0]   q_count;

    logic push;
    logic pop;

    // Word memory, 2**MEM_ADDR_W words
    mem_data_t mem_q [2**`MEM_ADDR_W];

    // Read latency pipeline
    logic      rd_vld [LAT];
    mem_data_t rd_dat [LAT];

    // Head entry of the queue
    logic        pop_write;
    mem_addr_t   pop_addr;
    mem_data_t   pop_wdata;
    mem_byteen_t pop_be;

    // Pipe already filtered waitrequest, so every arrival is kept
    assign push = snk_read || snk_write;
    assign pop  = !sink_stall && (q_count != '0);

    assign pop_write = q_write[rd_ptr];
    assign pop_addr  = q_addr[rd_ptr];
    assign pop_wdata = q_wdata[rd_ptr];
    assign pop_be    = q_be[rd_ptr];

    // Almost full, few enough free entries left for the stages in flight
    assign snk_waitrequest = (DEPTH - int'(q_count)) <= SLACK;

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge mem_sink or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_count <= q_count + (Q_AW+1)'(push) - (Q_AW+1)'(pop);
        end
    end

    always_ff @(posedge mem_sink)
    begin
        if (push)
        begin
            q_write[wr_ptr] <= snk_write;
            q_addr[wr_ptr]  <= snk_address;
            q_wdata[wr_ptr] <= snk_writedata;
            q_be[wr_ptr]    <= snk_byteenable;
        end
    end

    // Popped write merges only the enabled bytes
    always_ff @(posedge mem_sink)
    begin
        if (pop && pop_write)
        begin
            for (int b = 0; b < NB; b++)
            begin
                if (pop_be[b])
                begin
                    mem_q[pop_addr][8*b +: 8] <= pop_wdata[8*b +: 8];
                end
            end
        end
        rd_dat[0] <= mem_q[pop_addr];
        for (int i = 1; i < LAT; i++)
        begin
            rd_dat[i] <= rd_dat[i-1];
        end
    end

    always_ff @(posedge mem_sink or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < LAT; i++)
            begin
                rd_vld[i] <= 1'b0;
            end
        end
        else
        begin
            rd_vld[0] <= pop && !pop_write;
            for (int i = 1; i < LAT; i++)
            begin
                rd_vld[i] <= rd_vld[i-1];
            end
        end
    end

    assign snk_readdatavalid = rd_vld[LAT-1];
    assign snk_readdata      = rd_dat[LAT-1];

    // Slack on waitrequest must cover the whole pipe, else a request is lost
    a_no_push_full: assert property (@(posedge mem_sink) disable iff (!rst_n)
        (q_count == (Q_AW+1)'(DEPTH)) |-> !push);

endmodule

`default_nettype wire

/* hw/mem_pipe_pkg.sv */
// **************************************************
// Shared types for the memory path, imported by RTL
// **************************************************
`default_nettype none

`include "mem_pipe_settings.svh"

package mem_pipe_pkg;

    // Word address into the sink memory
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    // One data word
    typedef logic [`MEM_DATA_W-1:0] mem_data_t;

    // One bit per byte of a word
    typedef logic [`MEM_DATA_W/8-1:0] mem_byteen_t;

    // Decoder either waits for a command or holds a request
    typedef enum logic
    {
        DEC_IDLE,
        DEC_HOLD
    } dec_state_t;

endpackage

`default_nettype wire

/* hw/mem_pipe_settings.svh */
// **************************************************
// Widths, depths and stage counts for the memory path
// **************************************************
`ifndef MEM_PIPE_SETTINGS_SVH
`define MEM_PIPE_SETTINGS_SVH

// Word address, 256 words of memory
`define MEM_ADDR_W 8

// Data word, one byte enable per byte
`define MEM_DATA_W 32

// Register stages on requests and on responses
`define MEM_REG_STAGES 2

// Waitrequest delay stages, source side sees it this late
`define MEM_WR_STAGES 2

// Sink request queue, power of two
`define MEM_QUEUE_DEPTH 8

// Cycles from a read's pop to its data
`define MEM_READ_LAT 2

`endif

/* hw/mem_pipe_top.sv */
// **************************************************
// Top level, decoder to pipe to sink, results back
// **************************************************
`default_nettype none

`include "mem_pipe_settings.svh"

module mem_pipe_top
(
    input  wire                            mem_sink,
    input  wire                            rst_n,
    input  wire                            cmd_valid,
    input  wire                            cmd_write,
    input  wire mem_pipe_pkg::mem_addr_t   cmd_addr,
    input  wire mem_pipe_pkg::mem_data_t   cmd_wdata,
    input  wire mem_pipe_pkg::mem_byteen_t cmd_byteen,
    input  wire                            sink_stall,
    output logic                           cmd_ready,
    output logic                           rsp_valid,
    output mem_pipe_pkg::mem_data_t        rsp_data,
    output logic                           rd_idle
);
    // Master side of the register pipe
    logic                      rd_accept;
    logic                      src_read;
    logic                      src_write;
    mem_pipe_pkg::mem_addr_t   src_address;
    mem_pipe_pkg::mem_data_t   src_writedata;
    mem_pipe_pkg::mem_byteen_t src_byteenable;
    logic                      src_waitrequest;
    mem_pipe_pkg::mem_data_t   src_readdata;
    logic                      src_readdatavalid;

    // Sink side of the register pipe
    logic                      snk_read;
    logic                      snk_write;
    mem_pipe_pkg::mem_addr_t   snk_address;
    mem_pipe_pkg::mem_data_t   snk_writedata;
    mem_pipe_pkg::mem_byteen_t snk_byteenable;
    logic                      snk_waitrequest;
    mem_pipe_pkg::mem_data_t   snk_readdata;
    logic                      snk_readdatavalid;

    req_decode u_decode
    (
        .mem_sink, .rst_n,
        .cmd_valid, .cmd_write, .cmd_addr, .cmd_wdata, .cmd_byteen,
        .src_waitrequest,
        .cmd_ready, .rd_accept,
        .src_read, .src_write, .src_address, .src_writedata, .src_byteenable
    );

    avmm_reg_pipe u_pipe
    (
        .mem_sink, .rst_n,
        .src_read, .src_write, .src_address, .src_writedata, .src_byteenable,
        .snk_waitrequest, .snk_readdata, .snk_readdatavalid,
        .src_waitrequest, .src_readdata, .src_readdatavalid,
        .snk_read, .snk_write, .snk_address, .snk_writedata, .snk_byteenable
    );

    mem_exec u_exec
    (
        .mem_sink, .rst_n, .sink_stall,
        .snk_read, .snk_write, .snk_address, .snk_writedata, .snk_byteenable,
        .snk_waitrequest, .snk_readdata, .snk_readdatavalid
    );

    rsp_collect u_collect
    (
        .mem_sink, .rst_n,
        .rd_accept, .src_readdata, .src_readdatavalid,
        .rsp_valid, .rsp_data, .rd_idle
    );

endmodule

`default_nettype wire

/* hw/req_decode.sv */
// **************************************************
// Decode stage, host command to held Avalon request
// **************************************************
`default_nettype none

`include "mem_pipe_settings.svh"

module req_decode
(
    input  wire                       mem_sink,
    input  wire                       rst_n,
    input  wire                       cmd_valid,
    input  wire                       cmd_write,
    input  wire mem_pipe_pkg::mem_addr_t   cmd_addr,
    input  wire mem_pipe_pkg::mem_data_t   cmd_wdata,
    input  wire mem_pipe_pkg::mem_byteen_t cmd_byteen,
    input  wire                       src_waitrequest,
    output logic                      cmd_ready,
    output logic                      rd_accept,
    output logic                      src_read,
    output logic                      src_write,
    output mem_pipe_pkg::mem_addr_t   src_address,
    output mem_pipe_pkg::mem_data_t   src_writedata,
    output mem_pipe_pkg::mem_byteen_t src_byteenable
);
    import mem_pipe_pkg::*;

    dec_state_t  state;
    logic        hold_write;
    mem_addr_t   hold_addr;
    mem_data_t   hold_wdata;
    mem_byteen_t hold_be;

    // Held request leaves on a cycle with waitrequest low
    logic        req_taken;

    assign req_taken = (state == DEC_HOLD) && !src_waitrequest;

    // Room for a new command when idle or when the held one goes now
    assign cmd_ready = (state == DEC_IDLE) || req_taken;

    always_ff @(posedge mem_sink or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= DEC_IDLE;
        end
        else if (cmd_valid && cmd_ready)
        begin
            state <= DEC_HOLD;
        end
        else if (req_taken)
        begin
            state <= DEC_IDLE;
        end
    end

    // Command payload, loaded only on accept
    always_ff @(posedge mem_sink)
    begin
        if (cmd_valid && cmd_ready)
        begin
            hold_write <= cmd_write;
            hold_addr  <= cmd_addr;
            hold_wdata <= cmd_wdata;
            hold_be    <= cmd_byteen;
        end
    end

    assign src_read       = (state == DEC_HOLD) && !hold_write;
    assign src_write      = (state == DEC_HOLD) && hold_write;
    assign src_address    = hold_addr;
    assign src_writedata  = hold_wdata;
    assign src_byteenable = hold_be;

    // One pulse per read that actually enters the pipe
    assign rd_accept = src_read && !src_waitrequest;

    // Avalon master rule, request frozen under waitrequest
    a_req_stable: assert property (@(posedge mem_sink) disable iff (!rst_n)
        (src_read || src_write) && src_waitrequest |=>
            $stable({src_read, src_write, src_address, src_writedata, src_byteenable}));

endmodule

`default_nettype wire

/* hw/rsp_collect.sv */
// **************************************************
// Result stage, registers read data for the host
// **************************************************
`default_nettype none

`include "mem_pipe_settings.svh"

module rsp_collect
(
    input  wire                          mem_sink,
    input  wire                          rst_n,
    input  wire                          rd_accept,
    input  wire mem_pipe_pkg::mem_data_t src_readdata,
    input  wire                          src_readdatavalid,
    output logic                         rsp_valid,
    output mem_pipe_pkg::mem_data_t      rsp_data,
    output logic                         rd_idle
);
    import mem_pipe_pkg::*;

    // Bound on reads between decoder and host, with some margin
    localparam int OUT_W = $clog2(`MEM_QUEUE_DEPTH + 2 * `MEM_REG_STAGES +
                                  `MEM_WR_STAGES + `MEM_READ_LAT + 2) + 1;

    logic [OUT_W-1:0] rd_cnt;
    mem_data_t        data_q;

    always_ff @(posedge mem_sink or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rsp_valid <= 1'b0;
            rd_cnt    <= '0;
        end
        else
        begin
            rsp_valid <= src_readdatavalid;
            // up on an accepted read, down on its data
            rd_cnt    <= rd_cnt + OUT_W'(rd_accept) - OUT_W'(src_readdatavalid);
        end
    end

    always_ff @(posedge mem_sink)
    begin
        if (src_readdatavalid)
        begin
            data_q <= src_readdata;
        end
    end

    assign rsp_data = data_q;
    assign rd_idle  = (rd_cnt == '0);

    // Data with nothing outstanding means the sink made up a read
    a_no_orphan_rsp: assert property (@(posedge mem_sink) disable iff (!rst_n)
        src_readdatavalid |-> (rd_cnt != '0));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module mem_pipe_tb \
    -Mdir obj_dir \
    -o mem_pipe_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/mem_pipe_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished cleanly"
exit 0

/* sim/mem_pipe_patterns.txt */
// Columns: op addr wdata byteen expected, all hex
// op 0 write, 1 read and compare, 2 long sink stall for addr cycles, f end
// Full-word write, then read back
0 10 11223344 f 00000000
1 10 00000000 0 11223344
// Partial byte enables merge into the old word
0 11 aabbccdd f 00000000
0 11 00005500 2 00000000
1 11 00000000 0 aabb55dd
0 12 01020304 f 00000000
0 12 f0e0d0c0 9 00000000
1 12 00000000 0 f00203c0
// Fill a block, then read it back to back
0 20 a0a00020 f 00000000
0 21 b1b10021 f 00000000
0 22 c2c20022 f 00000000
0 23 d3d30023 f 00000000
0 24 e4e40024 f 00000000
1 20 00000000 0 a0a00020
1 22 00000000 0 c2c20022
1 21 00000000 0 b1b10021
1 24 00000000 0 e4e40024
1 23 00000000 0 d3d30023
// Long stall fills the sink queue and raises waitrequest
2 28 00000000 0 00000000
0 30 13572468 f 00000000
0 31 fedcba98 f 00000000
1 30 00000000 0 13572468
1 31 00000000 0 fedcba98
1 10 00000000 0 11223344
1 11 00000000 0 aabb55dd
1 12 00000000 0 f00203c0
0 30 0000ff00 2 00000000
1 30 00000000 0 1357ff68
1 20 00000000 0 a0a00020
f 00 00000000 0 00000000

/* sim/mem_pipe_tb.sv */
// **************************************************
// Self-checking testbench, commands from the pattern file
// **************************************************
`default_nettype none

`include "mem_pipe_settings.svh"

module mem_pipe_tb;
    import mem_pipe_pkg::*;

    // Five hex words per pattern line
    localparam int FIELDS      = 5;
    localparam int MAX_CMDS    = 64;
    localparam int PAT_WORDS   = FIELDS * MAX_CMDS;
    localparam int PAT_AW      = $clog2(PAT_WORDS);
    localparam int CMD_TIMEOUT = 200;
    localparam int END_TIMEOUT = 400;

    // Op codes in the first column
    localparam logic [31:0] OP_WRITE = 32'h0;
    localparam logic [31:0] OP_READ  = 32'h1;
    localparam logic [31:0] OP_STALL = 32'h2;
    localparam logic [31:0] OP_END   = 32'hf;

    logic        mem_sink;
    logic        rst_n;
    logic        cmd_valid;
    logic        cmd_write;
    mem_addr_t   cmd_addr;
    mem_data_t   cmd_wdata;
    mem_byteen_t cmd_byteen;
    logic        sink_stall;
    logic        cmd_ready;
    logic        rsp_valid;
    mem_data_t   rsp_data;
    logic        rd_idle;

    logic [31:0] pat [PAT_WORDS];

    // Read data still owed by the DUT, oldest first
    mem_data_t exp_q [$];

    integer seed         = 32'h99ef5b0e;
    int     stall_left   = 0;
    logic   wr_seen      = 1'b0;

    mem_pipe_top u_dut
    (
        .mem_sink   (mem_sink),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_write  (cmd_write),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .cmd_byteen (cmd_byteen),
        .sink_stall (sink_stall),
        .cmd_ready  (cmd_ready),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rd_idle    (rd_idle)
    );

    initial
    begin
        mem_sink = 1'b0;
        forever
        begin
            #2 mem_sink = ~mem_sink;
        end
    end

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "simulation stopped on mismatch");
        end
    endtask

    // Entered and left just after a rising edge
    task automatic issue_cmd(input logic wr, input mem_addr_t addr,
                             input mem_data_t wdata, input mem_byteen_t be);
        int waited;
        waited     = 0;
        cmd_valid  = 1'b1;
        cmd_write  = wr;
        cmd_addr   = addr;
        cmd_wdata  = wdata;
        cmd_byteen = be;
        // cmd_ready only moves on the edge, so it is settled here
        while (!cmd_ready)
        begin
            if (waited >= CMD_TIMEOUT)
            begin
                abort_run("cmd_ready stayed low, command was never accepted");
            end
            else
            begin
                @(posedge mem_sink);
                #1;
                waited++;
            end
        end
        @(posedge mem_sink);
        #1;
        cmd_valid = 1'b0;
    endtask

    // Sink stall, random or forced by a stall line
    initial
    begin
        logic next_stall;
        sink_stall = 1'b0;
        forever
        begin
            @(negedge mem_sink);
            if (stall_left > 0)
            begin
                next_stall = 1'b1;
                stall_left--;
            end
            else
            begin
                // Roughly one cycle in four
                next_stall = (($random(seed) & 3) == 0);
            end
            @(posedge mem_sink);
            #1;
            sink_stall = next_stall;
        end
    end

    // Responses checked mid-cycle, where rsp_valid and rsp_data are settled
    initial
    begin
        mem_data_t exp;
        forever
        begin
            @(negedge mem_sink);
            if (rst_n && u_dut.snk_waitrequest)
            begin
                wr_seen = 1'b1;
            end
            if (rst_n && rsp_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    abort_run("response arrived with no read outstanding");
                end
                else
                begin
                    exp = exp_q.pop_front();
                    check_value("rsp_data", rsp_data, exp);
                end
            end
        end
    end

    initial
    begin
        int               idx;
        int               waited;
        logic             done;
        logic [PAT_AW-1:0] base;
        logic [31:0]      op;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_write  = 1'b0;
        cmd_addr   = '0;
        cmd_wdata  = '0;
        cmd_byteen = '0;
        $readmemh("sim/mem_pipe_patterns.txt", pat);

        repeat (2) @(posedge mem_sink);
        #1;
        rst_n = 1'b1;

        // Idle state straight out of reset
        check_value("cmd_ready", 32'(cmd_ready), 32'd1);
        check_value("rd_idle", 32'(rd_idle), 32'd1);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);

        idx  = 0;
        done = 1'b0;
        while (!done)
        begin
            if (idx >= MAX_CMDS)
            begin
                abort_run("pattern file has no end line");
            end
            else
            begin
                base = PAT_AW'(FIELDS * idx);
                op   = pat[base];
                case (op)
                    OP_WRITE:
                    begin
                        issue_cmd(1'b1, pat[base + PAT_AW'(1)][`MEM_ADDR_W-1:0],
                                  pat[base + PAT_AW'(2)],
                                  pat[base + PAT_AW'(3)][`MEM_DATA_W/8-1:0]);
                    end
                    OP_READ:
                    begin
                        // Expected word queued before the read can return
                        exp_q.push_back(pat[base + PAT_AW'(4)]);
                        issue_cmd(1'b0, pat[base + PAT_AW'(1)][`MEM_ADDR_W-1:0],
                                  '0, '0);
                    end
                    OP_STALL:
                    begin
                        stall_left = int'(pat[base + PAT_AW'(1)]);
                    end
                    OP_END:
                    begin
                        done = 1'b1;
                    end
                    default:
                    begin
                        abort_run("unknown op code in pattern file");
                    end
                endcase
                idx++;
            end
        end

        // Drain every read still in flight
        waited = 0;
        while (!(rd_idle && (exp_q.size() == 0)))
        begin
            if (waited >= END_TIMEOUT)
            begin
                abort_run("timed out waiting for outstanding reads");
            end
            else
            begin
                @(posedge mem_sink);
                #1;
                waited++;
            end
        end

        check_value("snk_waitrequest seen", 32'(wr_seen), 32'd1);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
